// File: arrayBank.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Storage bank of one array
// Store, load and element arithmetic with write back
//----------------------------------------------------------
module arrayBank (
  input  logic                  clock,
  input  logic                  reset,
  input  memoryPkg::bankRequest request,
  output memoryPkg::bankReply   reply
);

  memoryPkg::elementData storage [memoryPkg::ArrayLength];
  memoryPkg::elementData oldValue;                  // Element before the operation
  memoryPkg::elementData newValue;
  memoryPkg::elementData result;
  logic                  writeBack;
  logic                  replyValid;
  memoryPkg::elementData replyData;

  assign oldValue = storage[request.index];

  always_comb begin
    newValue  = oldValue;
    writeBack = 1'b1;
    case (request.op)
      memoryPkg::opStore:    newValue = request.operand;
      memoryPkg::opAdd,
      memoryPkg::opAddAfter: newValue = oldValue + request.operand;
      memoryPkg::opSubtract,
      memoryPkg::opSubAfter: newValue = oldValue - request.operand;
      memoryPkg::opBitNot:   newValue = ~oldValue;
      memoryPkg::opBitOr:    newValue = oldValue | request.operand;
      memoryPkg::opBitXor:   newValue = oldValue ^ request.operand;
      memoryPkg::opBitAnd:   newValue = oldValue & request.operand;
      default:               writeBack = 1'b0;     // Load leaves storage alone
    endcase
  end

  // The after forms hand back the element as it was
  assign result = (request.op == memoryPkg::opAddAfter || request.op == memoryPkg::opSubAfter)
                ? oldValue : newValue;

  always_ff @(posedge clock) begin
    if (request.valid && writeBack) begin
      storage[request.index] <= newValue;
    end
    if (request.valid) begin
      replyData <= result;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      replyValid <= 1'b0;
    end else begin
      replyValid <= request.valid;
    end
  end

  assign reply = '{valid: replyValid, data: replyData};

  assert property (@(posedge clock) disable iff (!reset)
                   request.valid |=> reply.valid)
    else $error("Bank reply missing one cycle after its request");

  assert property (@(posedge clock) disable iff (!reset)
                   !request.valid |=> !reply.valid)
    else $error("Bank reply without a request");

endmodule

// File: arrayMemory.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Array memory top level
// Decoder, one bank per array and the reply collector
//----------------------------------------------------------
module arrayMemory #(
  parameter int arrayCount = 4                      // Number of arrays built up to MaxArrays
) (
  input  logic                     clock,
  input  logic                     reset,
  input  memoryPkg::memoryCommand  command,
  output memoryPkg::memoryResponse response
);

  memoryPkg::bankRequest [arrayCount-1:0] requests;
  memoryPkg::decoderReply                 decoded;
  memoryPkg::bankReply [arrayCount-1:0]   bankReplies;

  commandDecoder #(
    .arrayCount(arrayCount)
  ) i_commandDecoder (
    .clock   (clock),
    .reset   (reset),
    .command (command),
    .requests(requests),
    .reply   (decoded)
  );

  for (genvar g = 0; g < arrayCount; g++) begin : bankGen
    arrayBank i_arrayBank (
      .clock  (clock),
      .reset  (reset),
      .request(requests[g]),
      .reply  (bankReplies[g])
    );
  end

  replyCollector #(
    .arrayCount(arrayCount)
  ) i_replyCollector (
    .clock      (clock),
    .reset      (reset),
    .decoded    (decoded),
    .bankReplies(bankReplies),
    .response   (response)
  );

endmodule

// File: arrayMemoryModel.svh
//----------------------------------------------------------
// Reference model of the array memory
// Model state and the function that applies one command
//----------------------------------------------------------
`ifndef ARRAY_MEMORY_MODEL_SVH
`define ARRAY_MEMORY_MODEL_SVH

logic                  modelAllocated [memoryPkg::MaxArrays];
memoryPkg::arraySize   modelSizes     [memoryPkg::MaxArrays];
memoryPkg::elementData modelElements  [memoryPkg::MaxArrays][memoryPkg::ArrayLength];

function automatic void modelClear();
  for (int i = 0; i < memoryPkg::MaxArrays; i++) begin
    modelAllocated[i] = 1'b0;
    modelSizes[i]     = '0;
  end
endfunction

function automatic void modelApply(input memoryPkg::memoryCommand cmd, input int arrayCount,
                                   output memoryPkg::elementData data,
                                   output memoryPkg::errorCode error);
  int                    a;
  int                    i;
  int                    found;
  logic                  live;
  memoryPkg::arraySize   size;
  memoryPkg::elementData old;
  a     = int'(cmd.array);
  data  = '0;
  error = memoryPkg::noError;
  live  = (a < arrayCount) && modelAllocated[a];
  size  = modelSizes[a];
  old   = modelElements[a][cmd.index];
  if (cmd.code == memoryPkg::cmdAlloc) begin
    found = -1;
    for (i = 0; i < arrayCount; i++) begin
      if (found < 0 && !modelAllocated[i]) found = i;
    end
    if (found < 0) begin
      error = memoryPkg::outOfMemory;
    end else begin
      modelAllocated[found] = 1'b1;
      modelSizes[found]     = '0;
      data                  = memoryPkg::elementData'(found);
    end
  end else if (cmd.code == memoryPkg::cmdIdle) begin
    data = '0;
  end else if (!live) begin
    error = memoryPkg::notAllocated;
  end else begin
    case (cmd.code)
      memoryPkg::cmdFree: begin
        modelAllocated[a] = 1'b0;
        modelSizes[a]     = '0;
      end
      memoryPkg::cmdWrite: begin
        modelElements[a][cmd.index] = cmd.operand;
        if (memoryPkg::arraySize'(cmd.index) >= size) modelSizes[a] = cmd.index + 1;
        data = cmd.operand;
      end
      memoryPkg::cmdSize: data = memoryPkg::elementData'(size);
      memoryPkg::cmdPush: begin
        if (size == memoryPkg::ArrayLength) begin
          error = memoryPkg::arrayFull;
        end else begin
          modelElements[a][size[memoryPkg::IndexBits-1:0]] = cmd.operand;
          modelSizes[a] = size + 1;
          data          = cmd.operand;
        end
      end
      memoryPkg::cmdPop: begin
        if (size == 0) begin
          error = memoryPkg::arrayEmpty;
        end else begin
          modelSizes[a] = size - 1;
          data          = modelElements[a][modelSizes[a][memoryPkg::IndexBits-1:0]];
        end
      end
      default: begin
        if (memoryPkg::arraySize'(cmd.index) >= size) begin
          error = memoryPkg::outOfBounds;
        end else begin
          case (cmd.code)
            memoryPkg::cmdAdd,
            memoryPkg::cmdAddAfter: modelElements[a][cmd.index] = old + cmd.operand;
            memoryPkg::cmdSubtract,
            memoryPkg::cmdSubAfter: modelElements[a][cmd.index] = old - cmd.operand;
            memoryPkg::cmdBitNot:   modelElements[a][cmd.index] = ~old;
            memoryPkg::cmdBitOr:    modelElements[a][cmd.index] = old | cmd.operand;
            memoryPkg::cmdBitXor:   modelElements[a][cmd.index] = old ^ cmd.operand;
            memoryPkg::cmdBitAnd:   modelElements[a][cmd.index] = old & cmd.operand;
            default:                modelElements[a][cmd.index] = old;
          endcase
          data = (cmd.code == memoryPkg::cmdAddAfter || cmd.code == memoryPkg::cmdSubAfter)
               ? old : modelElements[a][cmd.index];
        end
      end
    endcase
  end
endfunction

`endif

// File: arrayMemoryTb.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Testbench of the array memory
// Directed rule checks, LFSR random mix, queue comparison
//----------------------------------------------------------
module arrayMemoryTb;

  localparam int ArrayCount       = 4;
  localparam int ResetCycles      = 16;
  localparam int DirectedCommands = 104;            // Commands of the directed steps
  localparam int RandomCommands   = 600;
  localparam int CycleLimit       = ResetCycles + DirectedCommands + RandomCommands + 50;

  typedef struct packed {
    memoryPkg::elementData data;
    memoryPkg::errorCode   error;
    logic [31:0]           dueCycle;                // Cycle of the expected response
  } expectation;

  logic                     clock;
  logic                     reset;
  memoryPkg::memoryCommand  command;
  memoryPkg::memoryResponse response;

  expectation               expected [$];
  expectation               head;
  int                       cycleCount = 0;
  logic [15:0]              lfsr;
  int                       responseCount = 0;
  int                       dataErrors = 0;
  int                       codeErrors = 0;
  int                       latencyErrors = 0;
  int                       flowErrors = 0;         // Missing or unexpected responses
  int                       totalErrors;

  `include "arrayMemoryModel.svh"

  arrayMemory #(
    .arrayCount(ArrayCount)
  ) i_arrayMemory (
    .clock   (clock),
    .reset   (reset),
    .command (command),
    .response(response)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) cycleCount <= cycleCount + 1;

  initial begin
    wait (cycleCount >= CycleLimit);
    $display("Timeout: run did not finish within %0d cycles", CycleLimit);
    $display("Verification failed");
    $finish;
  end

  //----------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------
  function automatic logic [15:0] stepLfsr(input logic [15:0] state);
    logic lsb;
    lsb = state[0];
    stepLfsr = state >> 1;
    if (lsb) stepLfsr = stepLfsr ^ 16'hB400;         // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  function automatic int takeBits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = stepLfsr(lfsr);
    end
    return value;
  endfunction

  function automatic memoryPkg::elementData fillPattern(input int array, input int index);
    return memoryPkg::elementData'((array * memoryPkg::ArrayLength + index) * 16'h3B1D + 16'h0F0F);
  endfunction

  task automatic issueCommand(input memoryPkg::commandCode code, input int array,
                              input int index, input memoryPkg::elementData operand);
    memoryPkg::memoryCommand cmd;
    memoryPkg::elementData   data;
    memoryPkg::errorCode     error;
    cmd = '{valid: 1'b1, code: code, array: memoryPkg::arrayId'(array),
            index: memoryPkg::elementIndex'(index), operand: operand};
    @(posedge clock);
    #1;
    command = cmd;
    modelApply(cmd, ArrayCount, data, error);
    expected.push_back('{data: data, error: error, dueCycle: 32'(cycleCount + 3)});
  endtask

  //----------------------------------------------------------
  // Test steps
  //----------------------------------------------------------
  task automatic checkResetRules();
    for (int c = 2; c < 16; c++) begin              // Nothing allocated yet
      issueCommand(memoryPkg::commandCode'(c), c % 4, c % 8, 16'(16'h00A0 + c));
    end
    repeat (5) issueCommand(memoryPkg::cmdAlloc, 0, 0, '0);   // Fifth runs out
    issueCommand(memoryPkg::cmdFree, 2, 0, '0);
    issueCommand(memoryPkg::cmdAlloc, 0, 0, '0);
    issueCommand(memoryPkg::cmdFree, 1, 0, '0);
    issueCommand(memoryPkg::cmdFree, 1, 0, '0);     // Double free
    issueCommand(memoryPkg::cmdAlloc, 0, 0, '0);
  endtask

  task automatic fillArrays();
    for (int a = 0; a < ArrayCount; a++) begin
      for (int i = 0; i < memoryPkg::ArrayLength; i++) begin
        issueCommand(memoryPkg::cmdWrite, a, i, fillPattern(a, i));
      end
    end
  endtask

  task automatic checkSizeRules();
    issueCommand(memoryPkg::cmdFree, 0, 0, '0);
    issueCommand(memoryPkg::cmdAlloc, 0, 0, '0);    // Array 0 back with size zero
    issueCommand(memoryPkg::cmdWrite, 0, 3, 16'hBEEF);
    issueCommand(memoryPkg::cmdSize, 0, 0, '0);
    issueCommand(memoryPkg::cmdRead, 0, 3, '0);
    issueCommand(memoryPkg::cmdRead, 0, 4, '0);
    issueCommand(memoryPkg::cmdRead, 0, 7, '0);
    issueCommand(memoryPkg::cmdWrite, 0, 1, 16'h1234);
    issueCommand(memoryPkg::cmdRead, 0, 1, '0);
    issueCommand(memoryPkg::cmdSize, 0, 0, '0);
  endtask

  task automatic checkStackRules();
    issueCommand(memoryPkg::cmdFree, 1, 0, '0);
    issueCommand(memoryPkg::cmdAlloc, 0, 0, '0);
    for (int i = 0; i < 9; i++) begin               // Last push hits a full array
      issueCommand(memoryPkg::cmdPush, 1, 0, 16'(16'h1000 + i * 16'h0111));
    end
    issueCommand(memoryPkg::cmdSize, 1, 0, '0);
    repeat (9) issueCommand(memoryPkg::cmdPop, 1, 0, '0);
  endtask

  task automatic checkElementOps();
    for (int c = 8; c < 16; c++) begin
      issueCommand(memoryPkg::commandCode'(c), 2, c - 8, 16'(16'h0F0F + c * 16'h0101));
      issueCommand(memoryPkg::cmdRead, 2, c - 8, '0);   // Written back value
    end
    issueCommand(memoryPkg::cmdAdd, 0, 6, 16'h0001);    // Beyond size of array 0
  endtask

  task automatic runRandomMix();
    memoryPkg::commandCode code;
    int                    array;
    int                    index;
    memoryPkg::elementData operand;
    for (int n = 0; n < RandomCommands; n++) begin
      code    = memoryPkg::commandCode'(takeBits(5) % 16);
      array   = takeBits(memoryPkg::ArrayIdBits);
      index   = takeBits(memoryPkg::IndexBits);
      operand = memoryPkg::elementData'(takeBits(memoryPkg::DataBits));
      if (code == memoryPkg::cmdIdle) code = memoryPkg::cmdRead;
      issueCommand(code, array, index, operand);
    end
  endtask

  //----------------------------------------------------------
  // Comparison of responses
  //----------------------------------------------------------
  always @(negedge clock) begin
    if (reset) begin
      if (response.valid) begin
        responseCount++;
        if (expected.size() == 0) begin
          $display("%0t: a response arrived with no command outstanding", $time);
          flowErrors++;
        end else begin
          head = expected.pop_front();
          if (response.data !== head.data) begin
            $display("[ERROR] %0t response.data got %h expected %h",
                     $time, response.data, head.data);
            dataErrors++;
          end
          if (response.error !== head.error) begin
            $display("[ERROR] %0t response.error got %s expected %s",
                     $time, response.error.name(), head.error.name());
            codeErrors++;
          end
          if (int'(head.dueCycle) != cycleCount) begin
            $display("[ERROR] %0t response cycle got %0d expected %0d",
                     $time, cycleCount, head.dueCycle);
            latencyErrors++;
          end
        end
      end else if (expected.size() != 0 && int'(expected[0].dueCycle) <= cycleCount) begin
        $display("%0t: no response for the command due in cycle %0d",
                 $time, expected[0].dueCycle);
        head = expected.pop_front();
        flowErrors++;
      end
    end
  end

  initial begin
    command = '0;
    reset   = 1'b0;
    lfsr    = 16'd59586;
    modelClear();
    repeat (ResetCycles) @(posedge clock);
    #1 reset = 1'b1;
    checkResetRules();
    fillArrays();
    checkSizeRules();
    checkStackRules();
    checkElementOps();
    runRandomMix();
    @(posedge clock);
    #1 command = '0;
    while (expected.size() != 0) @(negedge clock);
    repeat (4) @(negedge clock);                    // Catch late extra responses
    totalErrors = dataErrors + codeErrors + latencyErrors + flowErrors;
    $display("Responses %0d, errors in data %0d, code %0d, latency %0d, flow %0d",
             responseCount, dataErrors, codeErrors, latencyErrors, flowErrors);
    if (totalErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: commandDecoder.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Command decoder of the array memory
// Allocation and size tables, rule checks, bank requests
//----------------------------------------------------------
module commandDecoder #(
  parameter int arrayCount = 4
) (
  input  logic                                   clock,
  input  logic                                   reset,
  input  memoryPkg::memoryCommand                command,
  output memoryPkg::bankRequest [arrayCount-1:0] requests,
  output memoryPkg::decoderReply                 reply
);

  logic                   allocated [arrayCount];   // Array in use
  memoryPkg::arraySize    sizes     [arrayCount];   // Current size of each array

  memoryPkg::arraySize    curSize;
  memoryPkg::arraySize    indexPlusOne;
  logic                   isLive;                   // Legal and allocated
  logic                   inBounds;
  logic                   freeFound;
  memoryPkg::arrayId      freeId;                   // Lowest free array

  logic                   tableWrite;
  memoryPkg::arrayId      tableTarget;
  logic                   nextAlloc;
  memoryPkg::arraySize    nextSize;
  logic                   useBank;
  memoryPkg::bankOp       nextOp;
  memoryPkg::elementIndex nextIndex;
  memoryPkg::elementData  nextData;
  memoryPkg::errorCode    nextError;

  logic [arrayCount-1:0]  reqValid;                 // One hot or zero
  memoryPkg::bankOp       reqOp;
  memoryPkg::elementIndex reqIndex;
  memoryPkg::elementData  reqOperand;
  logic                   replyValid;
  logic                   replyUsesBank;
  memoryPkg::arrayId      replyArray;
  memoryPkg::elementData  replyData;
  memoryPkg::errorCode    replyError;

  function automatic memoryPkg::bankOp opFor(memoryPkg::commandCode code);
    case (code)
      memoryPkg::cmdAdd:      return memoryPkg::opAdd;
      memoryPkg::cmdAddAfter: return memoryPkg::opAddAfter;
      memoryPkg::cmdSubtract: return memoryPkg::opSubtract;
      memoryPkg::cmdSubAfter: return memoryPkg::opSubAfter;
      memoryPkg::cmdBitNot:   return memoryPkg::opBitNot;
      memoryPkg::cmdBitOr:    return memoryPkg::opBitOr;
      memoryPkg::cmdBitXor:   return memoryPkg::opBitXor;
      memoryPkg::cmdBitAnd:   return memoryPkg::opBitAnd;
      default:                return memoryPkg::opLoad;   // Plain read
    endcase
  endfunction

  assign isLive       = (int'(command.array) < arrayCount) && allocated[command.array];
  assign curSize      = sizes[command.array];
  assign indexPlusOne = memoryPkg::arraySize'(command.index) + 1'b1;
  assign inBounds     = memoryPkg::arraySize'(command.index) < curSize;

  always_comb begin
    freeFound = 1'b0;
    freeId    = '0;
    for (int i = arrayCount - 1; i >= 0; i--) begin   // Lowest number wins
      if (!allocated[i]) begin
        freeFound = 1'b1;
        freeId    = memoryPkg::arrayId'(i);
      end
    end
  end

  //----------------------------------------------------------
  // Rule checks
  //----------------------------------------------------------
  always_comb begin
    tableWrite  = 1'b0;
    tableTarget = command.array;
    nextAlloc   = 1'b1;
    nextSize    = curSize;
    useBank     = 1'b0;
    nextOp      = memoryPkg::opLoad;
    nextIndex   = command.index;
    nextData    = '0;
    nextError   = memoryPkg::noError;
    if (command.code == memoryPkg::cmdAlloc) begin
      if (freeFound) begin
        tableWrite  = 1'b1;
        tableTarget = freeId;
        nextSize    = '0;                           // New array starts empty
        nextData    = memoryPkg::elementData'(freeId);
      end else begin
        nextError = memoryPkg::outOfMemory;
      end
    end else if (command.code != memoryPkg::cmdIdle) begin
      if (!isLive) begin
        nextError = memoryPkg::notAllocated;
      end else begin
        case (command.code)
          memoryPkg::cmdFree: begin
            tableWrite = 1'b1;
            nextAlloc  = 1'b0;
            nextSize   = '0;
          end
          memoryPkg::cmdWrite: begin
            tableWrite = 1'b1;
            useBank    = 1'b1;
            nextOp     = memoryPkg::opStore;
            if (!inBounds) begin
              nextSize = indexPlusOne;              // Write grows the array
            end
          end
          memoryPkg::cmdSize: begin
            nextData = memoryPkg::elementData'(curSize);
          end
          memoryPkg::cmdPush: begin
            if (curSize == memoryPkg::ArrayLength) begin
              nextError = memoryPkg::arrayFull;
            end else begin
              tableWrite = 1'b1;
              useBank    = 1'b1;
              nextOp     = memoryPkg::opStore;
              nextIndex  = memoryPkg::elementIndex'(curSize);
              nextSize   = curSize + 1'b1;
            end
          end
          memoryPkg::cmdPop: begin
            if (curSize == '0) begin
              nextError = memoryPkg::arrayEmpty;
            end else begin
              tableWrite = 1'b1;
              useBank    = 1'b1;
              nextSize   = curSize - 1'b1;
              nextIndex  = memoryPkg::elementIndex'(curSize - 1'b1);   // Top element
            end
          end
          default: begin                            // Read and element operations
            if (!inBounds) begin
              nextError = memoryPkg::outOfBounds;
            end else begin
              useBank = 1'b1;
              nextOp  = opFor(command.code);
            end
          end
        endcase
      end
    end
  end

  //----------------------------------------------------------
  // Tables and registered outputs
  //----------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < arrayCount; i++) begin
        allocated[i] <= 1'b0;
        sizes[i]     <= '0;
      end
      reqValid   <= '0;
      replyValid <= 1'b0;
    end else begin
      if (command.valid && tableWrite) begin
        allocated[tableTarget] <= nextAlloc;
        sizes[tableTarget]     <= nextSize;
      end
      for (int i = 0; i < arrayCount; i++) begin
        reqValid[i] <= command.valid && useBank && (int'(command.array) == i);
      end
      replyValid <= command.valid;
    end
  end

  always_ff @(posedge clock) begin
    reqOp         <= nextOp;
    reqIndex      <= nextIndex;
    reqOperand    <= command.operand;
    replyUsesBank <= useBank;
    replyArray    <= command.array;
    replyData     <= nextData;
    replyError    <= nextError;
  end

  for (genvar g = 0; g < arrayCount; g++) begin : requestGen
    assign requests[g] = '{valid: reqValid[g], op: reqOp, index: reqIndex, operand: reqOperand};

    assert property (@(posedge clock) disable iff (!reset) sizes[g] <= memoryPkg::ArrayLength)
      else $error("Array %0d size above its length", g);
  end

  assign reply = '{valid: replyValid, usesBank: replyUsesBank, array: replyArray,
                   data: replyData, error: replyError};

  assert property (@(posedge clock) disable iff (!reset) $onehot0(reqValid))
    else $error("More than one bank request in a cycle");

endmodule

// File: memoryPkg.sv
//----------------------------------------------------------
// Widths, vector types and encodings of the array memory
// Packed structs passed between decoder, banks and collector
//----------------------------------------------------------
package memoryPkg;

  localparam int ArrayIdBits = 2;                   // Bits in an array number
  localparam int IndexBits   = 3;                   // Bits in an element index
  localparam int DataBits    = 16;                  // Bits in an element
  localparam int ArrayLength = 1 << IndexBits;      // Elements per array
  localparam int MaxArrays   = 1 << ArrayIdBits;    // Largest legal array count

  typedef logic [ArrayIdBits-1:0] arrayId;
  typedef logic [IndexBits-1:0]   elementIndex;
  typedef logic [IndexBits:0]     arraySize;        // 0 to ArrayLength
  typedef logic [DataBits-1:0]    elementData;

  typedef enum logic [4:0] {
    cmdIdle,
    cmdAlloc,
    cmdFree,
    cmdWrite,
    cmdRead,
    cmdSize,
    cmdPush,
    cmdPop,
    cmdAdd,                                         // Returns new value
    cmdAddAfter,                                    // Returns old value
    cmdSubtract,
    cmdSubAfter,
    cmdBitNot,
    cmdBitOr,
    cmdBitXor,
    cmdBitAnd
  } commandCode;

  typedef enum logic [2:0] {
    noError,
    notAllocated,
    outOfBounds,
    arrayFull,
    arrayEmpty,
    outOfMemory
  } errorCode;

  // Storage operation carried out inside one bank
  typedef enum logic [3:0] {
    opStore,
    opLoad,
    opAdd,
    opAddAfter,
    opSubtract,
    opSubAfter,
    opBitNot,
    opBitOr,
    opBitXor,
    opBitAnd
  } bankOp;

  typedef struct packed {
    logic        valid;                             // One cycle strobe
    commandCode  code;
    arrayId      array;
    elementIndex index;
    elementData  operand;
  } memoryCommand;

  typedef struct packed {
    logic        valid;
    bankOp       op;
    elementIndex index;
    elementData  operand;
  } bankRequest;

  typedef struct packed {
    logic       valid;
    logic       usesBank;                           // Data comes from a bank
    arrayId     array;                              // Bank that answers
    elementData data;
    errorCode   error;
  } decoderReply;

  typedef struct packed {
    logic       valid;
    elementData data;
  } bankReply;

  typedef struct packed {
    logic       valid;
    elementData data;
    errorCode   error;
  } memoryResponse;

endpackage

// File: replyCollector.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Reply collector of the array memory
// Aligns decoder results with bank data, registers response
//----------------------------------------------------------
module replyCollector #(
  parameter int arrayCount = 4
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  memoryPkg::decoderReply               decoded,
  input  memoryPkg::bankReply [arrayCount-1:0] bankReplies,
  output memoryPkg::memoryResponse             response
);

  logic                  pendValid;                 // Decoder reply one stage late
  logic                  pendUsesBank;
  memoryPkg::arrayId     pendArray;
  memoryPkg::elementData pendData;
  memoryPkg::errorCode   pendError;
  memoryPkg::elementData selData;
  logic                  respValid;
  memoryPkg::elementData respData;
  memoryPkg::errorCode   respError;

  assign selData = pendUsesBank ? bankReplies[pendArray].data : pendData;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      pendValid <= 1'b0;
      respValid <= 1'b0;
    end else begin
      pendValid <= decoded.valid;
      respValid <= pendValid;
    end
  end

  always_ff @(posedge clock) begin
    pendUsesBank <= decoded.usesBank;
    pendArray    <= decoded.array;
    pendData     <= decoded.data;
    pendError    <= decoded.error;
    respData     <= selData;
    respError    <= pendError;                      // Bank work never fails
  end

  assign response = '{valid: respValid, data: respData, error: respError};

  // Decoder and bank paths must stay in step
  assert property (@(posedge clock) disable iff (!reset)
                   pendValid && pendUsesBank |-> bankReplies[pendArray].valid)
    else $error("No reply from bank %0d", pendArray);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the array memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module arrayMemoryTb -f src.f -o arrayMemorySim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/arrayMemorySim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: src.f
+incdir+.
memoryPkg.sv
commandDecoder.sv
arrayBank.sv
replyCollector.sv
arrayMemory.sv
arrayMemoryTb.sv
